// File: src.f
+incdir+source
source/iq_pkg.sv
source/wakeup_match.sv
source/issue_select.sv
source/dispatch_alloc.sv
source/entry_shift_queue.sv
source/issue_queue.sv
bench/tb_clock.sv
bench/issue_queue_tb.sv

// File: Bender.yml
package:
  name: issue_queue

sources:
  - include_dirs:
      - source
    files:
      - source/iq_pkg.sv
      - source/wakeup_match.sv
      - source/issue_select.sv
      - source/dispatch_alloc.sv
      - source/entry_shift_queue.sv
      - source/issue_queue.sv
  - target: test
    include_dirs:
      - source
    files:
      - bench/tb_clock.sv
      - bench/issue_queue_tb.sv

// File: bench/issue_queue_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "iq_settings.svh"

module issue_queue_tb;

    localparam int row_count = 21;
    localparam int op_count = 18;
    localparam int reset_cycles = 16;

    logic CLK;
    logic nRST;
    logic [`DISPATCH_WAYS-1:0] dispatch_attempt, dispatch_valid_alu_reg, dispatch_valid_mul_div;
    iq_pkg::op_t [`DISPATCH_WAYS-1:0] dispatch_op;
    iq_pkg::pr_t [`DISPATCH_WAYS-1:0] dispatch_A_pr, dispatch_B_pr, dispatch_dest_pr;
    logic [`DISPATCH_WAYS-1:0] dispatch_A_ready, dispatch_B_ready, dispatch_ack;
    iq_pkg::rob_t [`DISPATCH_WAYS-1:0] dispatch_rob_index;
    logic alu_reg_pipeline_ready, mul_div_pipeline_ready;
    logic [(1 << `BANK_BITS)-1:0] wb_valid;
    iq_pkg::upper_pr_t [(1 << `BANK_BITS)-1:0] wb_upper_pr;
    logic issue_alu_reg_valid, issue_alu_reg_A_forward, issue_alu_reg_B_forward;
    logic issue_mul_div_valid, issue_mul_div_A_forward, issue_mul_div_B_forward;
    iq_pkg::op_t issue_alu_reg_op, issue_mul_div_op;
    iq_pkg::pr_t issue_alu_reg_A_pr, issue_alu_reg_B_pr, issue_alu_reg_dest_pr;
    iq_pkg::pr_t issue_mul_div_A_pr, issue_mul_div_B_pr, issue_mul_div_dest_pr;
    iq_pkg::rob_t issue_alu_reg_rob_index, issue_mul_div_rob_index;

    // operation pool
    // kind 1 is ALU and kind 2 is multiply-divide
    // the rob index of an operation is its slot
    int op_kind [op_count];
    logic [`OP_BITS-1:0] op_code [op_count];
    logic [`PR_BITS-1:0] op_a [op_count];
    logic [`PR_BITS-1:0] op_b [op_count];
    logic [`PR_BITS-1:0] op_dest [op_count];
    bit op_a_rdy [op_count];
    bit op_b_rdy [op_count];

    // one row per cycle
    // -1 means none
    int row_way [row_count][`DISPATCH_WAYS];
    int row_wb [row_count];
    bit row_alu_rdy [row_count], row_md_rdy [row_count];
    bit [1:0] row_ack [row_count];
    int row_alu [row_count], row_md [row_count];
    bit [1:0] row_alu_fwd [row_count], row_md_fwd [row_count];
    int n_rows;
    int errors;
    int checks;

    tb_clock u_clock (.CLK);

    issue_queue u_dut (.*);

    task automatic add_row(input int w0, input int w1, input int wb, input bit alu_rdy,
            input bit md_rdy, input bit [1:0] ack, input int alu, input bit [1:0] alu_fwd,
            input int md, input bit [1:0] md_fwd);
        row_way[n_rows][0] = w0;
        row_way[n_rows][1] = w1;
        row_wb[n_rows] = wb;
        row_alu_rdy[n_rows] = alu_rdy;
        row_md_rdy[n_rows] = md_rdy;
        row_ack[n_rows] = ack;
        row_alu[n_rows] = alu;
        row_alu_fwd[n_rows] = alu_fwd;
        row_md[n_rows] = md;
        row_md_fwd[n_rows] = md_fwd;
        n_rows++;
    endtask

    task automatic fill_pool();
        int i;
        for (i = 0; i < op_count; i++) begin
            op_kind[i] = 1;
            op_code[i] = 4'(i);
            op_a[i] = 6'(i);
            op_a_rdy[i] = 1'b1;
            op_b[i] = 6'(16 + i);
            op_b_rdy[i] = 1'b1;
            op_dest[i] = 6'(32 + i);
        end
        op_kind[2] = 2;
        op_kind[8] = 2;
        // waiting on registers 45 (bank 1) and 46 (bank 2)
        op_a[6] = 6'd45;
        op_a_rdy[6] = 1'b0;
        op_a[7] = 6'd46;
        op_a_rdy[7] = 1'b0;
        // source B of op 8 waits on register 47 (bank 3)
        op_b[8] = 6'd47;
        op_b_rdy[8] = 1'b0;
    endtask

    // field order is way 0, way 1, wb reg, alu rdy, md rdy, acks, alu op, alu fwd, md op, md fwd
    task automatic build_table();
        add_row( 0,  1, -1, 1, 1, 2'b11, -1, 2'b00, -1, 2'b00);
        add_row(-1, -1, -1, 1, 1, 2'b00,  0, 2'b00, -1, 2'b00);
        add_row(-1, -1, -1, 1, 1, 2'b00,  1, 2'b00, -1, 2'b00);
        // dual issue followed by the two-place collapse
        add_row( 2,  3, -1, 0, 0, 2'b11, -1, 2'b00, -1, 2'b00);
        add_row( 4,  5, -1, 0, 0, 2'b11, -1, 2'b00, -1, 2'b00);
        add_row(-1, -1, -1, 1, 1, 2'b00,  3, 2'b00,  2, 2'b00);
        add_row( 6, -1, -1, 1, 1, 2'b01,  4, 2'b00, -1, 2'b00);
        add_row(-1, -1, -1, 1, 1, 2'b00,  5, 2'b00, -1, 2'b00);
        // wakeup from the writeback bus
        add_row(-1, -1, -1, 1, 1, 2'b00, -1, 2'b00, -1, 2'b00);
        add_row(-1, -1, 45, 1, 1, 2'b00,  6, 2'b10, -1, 2'b00);
        add_row( 7, -1, -1, 1, 1, 2'b01, -1, 2'b00, -1, 2'b00);
        add_row(-1, -1, 46, 0, 1, 2'b00, -1, 2'b00, -1, 2'b00);
        add_row(-1, -1, -1, 1, 1, 2'b00,  7, 2'b00, -1, 2'b00);
        // fill while both pipelines stall
        add_row( 8,  9, -1, 0, 0, 2'b11, -1, 2'b00, -1, 2'b00);
        add_row(10, 11, -1, 0, 0, 2'b11, -1, 2'b00, -1, 2'b00);
        add_row(12, 13, -1, 0, 0, 2'b11, -1, 2'b00, -1, 2'b00);
        add_row(14, 15, -1, 0, 0, 2'b11, -1, 2'b00, -1, 2'b00);
        add_row(16, 17, -1, 0, 0, 2'b00, -1, 2'b00, -1, 2'b00);
        add_row(16, 17, -1, 1, 1, 2'b00,  9, 2'b00, -1, 2'b00);
        add_row(16, 17, -1, 0, 0, 2'b01, -1, 2'b00, -1, 2'b00);
        add_row(-1, -1, 47, 1, 1, 2'b00, 10, 2'b00,  8, 2'b01);
    endtask

    task automatic drive_idle();
        dispatch_attempt = '0;
        dispatch_valid_alu_reg = '0;
        dispatch_valid_mul_div = '0;
        dispatch_op = '0;
        dispatch_A_pr = '0;
        dispatch_A_ready = '0;
        dispatch_B_pr = '0;
        dispatch_B_ready = '0;
        dispatch_dest_pr = '0;
        dispatch_rob_index = '0;
        alu_reg_pipeline_ready = 1'b0;
        mul_div_pipeline_ready = 1'b0;
        wb_valid = '0;
        wb_upper_pr = '0;
    endtask

    task automatic drive_row(input int r);
        int w;
        int idx;
        drive_idle();
        for (w = 0; w < `DISPATCH_WAYS; w++) begin
            idx = row_way[r][w];
            if (idx >= 0) begin
                dispatch_attempt[w] = 1'b1;
                dispatch_valid_alu_reg[w] = (op_kind[idx] == 1);
                dispatch_valid_mul_div[w] = (op_kind[idx] == 2);
                dispatch_op[w] = op_code[idx];
                dispatch_A_pr[w] = op_a[idx];
                dispatch_A_ready[w] = op_a_rdy[idx];
                dispatch_B_pr[w] = op_b[idx];
                dispatch_B_ready[w] = op_b_rdy[idx];
                dispatch_dest_pr[w] = op_dest[idx];
                dispatch_rob_index[w] = 6'(idx);
            end
        end
        // bank is the low bits and the upper bits ride on that bank
        if (row_wb[r] >= 0) begin
            wb_valid[row_wb[r] % (1 << `BANK_BITS)] = 1'b1;
            wb_upper_pr[row_wb[r] % (1 << `BANK_BITS)] = 4'(row_wb[r] >> `BANK_BITS);
        end
        alu_reg_pipeline_ready = row_alu_rdy[r];
        mul_div_pipeline_ready = row_md_rdy[r];
    endtask

    task automatic report_mismatch(input string msg);
        errors++;
        $display("[FAIL] %0t: %s", $time, msg);
    endtask

    // ------------------------------
    // output checks

    task automatic check_port(input string name, input int r, input int idx,
            input bit [1:0] fwd, input logic valid, input iq_pkg::op_t op,
            input logic [1:0] act_fwd, input iq_pkg::pr_t a, input iq_pkg::pr_t b,
            input iq_pkg::pr_t dest, input iq_pkg::rob_t rob);
        checks++;
        if (idx < 0) begin
            if (valid !== 1'b0) begin
                report_mismatch($sformatf("row %0d %s valid expected 0 got %b", r, name, valid));
            end
        end else if (valid !== 1'b1) begin
            report_mismatch($sformatf("row %0d %s valid expected 1 got %b", r, name, valid));
        end else if (op !== op_code[idx] || act_fwd !== fwd || a !== op_a[idx]
                || b !== op_b[idx] || dest !== op_dest[idx] || rob !== 6'(idx)) begin
            report_mismatch($sformatf(
                "row %0d %s exp rob %0d op %0d a %0d b %0d d %0d f %b got %0d %0d %0d %0d %0d %b",
                r, name, idx, op_code[idx], op_a[idx], op_b[idx], op_dest[idx], fwd,
                rob, op, a, b, dest, act_fwd));
        end
    endtask

    task automatic check_row(input int r);
        checks++;
        if (dispatch_ack !== row_ack[r]) begin
            report_mismatch($sformatf("row %0d ack expected %b got %b", r, row_ack[r],
                dispatch_ack));
        end
        check_port("alu_reg", r, row_alu[r], row_alu_fwd[r], issue_alu_reg_valid,
            issue_alu_reg_op, {issue_alu_reg_A_forward, issue_alu_reg_B_forward},
            issue_alu_reg_A_pr, issue_alu_reg_B_pr, issue_alu_reg_dest_pr,
            issue_alu_reg_rob_index);
        check_port("mul_div", r, row_md[r], row_md_fwd[r], issue_mul_div_valid,
            issue_mul_div_op, {issue_mul_div_A_forward, issue_mul_div_B_forward},
            issue_mul_div_A_pr, issue_mul_div_B_pr, issue_mul_div_dest_pr,
            issue_mul_div_rob_index);
    endtask

    initial begin : watchdog
        #((row_count + reset_cycles) * 10 + 200);
        $display("timeout: the stimulus table did not complete in time");
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin : main
        int r;
        errors = 0;
        checks = 0;
        n_rows = 0;
        nRST = 1'b0;
        drive_idle();
        fill_pool();
        build_table();
        repeat (reset_cycles) @(posedge CLK);
        #1;
        nRST = 1'b1;
        // drive 1 ns after the edge and sample 2 ns before the next one
        for (r = 0; r < n_rows; r++) begin
            drive_row(r);
            #7;
            check_row(r);
            @(posedge CLK);
            #1;
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter real half_period = 5.0
) (
    output logic CLK
);

    // 10 ns period
    initial begin
        CLK = 1'b0;
        forever #(half_period) CLK = ~CLK;
    end

endmodule

`default_nettype wire

// File: source/issue_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "iq_settings.svh"

module issue_queue (
    input logic CLK,
    input logic nRST,
    input logic [`DISPATCH_WAYS-1:0] dispatch_attempt,
    input logic [`DISPATCH_WAYS-1:0] dispatch_valid_alu_reg,
    input logic [`DISPATCH_WAYS-1:0] dispatch_valid_mul_div,
    input iq_pkg::op_t [`DISPATCH_WAYS-1:0] dispatch_op,
    input iq_pkg::pr_t [`DISPATCH_WAYS-1:0] dispatch_A_pr,
    input logic [`DISPATCH_WAYS-1:0] dispatch_A_ready,
    input iq_pkg::pr_t [`DISPATCH_WAYS-1:0] dispatch_B_pr,
    input logic [`DISPATCH_WAYS-1:0] dispatch_B_ready,
    input iq_pkg::pr_t [`DISPATCH_WAYS-1:0] dispatch_dest_pr,
    input iq_pkg::rob_t [`DISPATCH_WAYS-1:0] dispatch_rob_index,
    output logic [`DISPATCH_WAYS-1:0] dispatch_ack,
    input logic alu_reg_pipeline_ready,
    input logic mul_div_pipeline_ready,
    input logic [(1 << `BANK_BITS)-1:0] wb_valid,
    input iq_pkg::upper_pr_t [(1 << `BANK_BITS)-1:0] wb_upper_pr,
    output logic issue_alu_reg_valid,
    output iq_pkg::op_t issue_alu_reg_op,
    output logic issue_alu_reg_A_forward,
    output logic issue_alu_reg_B_forward,
    output iq_pkg::pr_t issue_alu_reg_A_pr,
    output iq_pkg::pr_t issue_alu_reg_B_pr,
    output iq_pkg::pr_t issue_alu_reg_dest_pr,
    output iq_pkg::rob_t issue_alu_reg_rob_index,
    output logic issue_mul_div_valid,
    output iq_pkg::op_t issue_mul_div_op,
    output logic issue_mul_div_A_forward,
    output logic issue_mul_div_B_forward,
    output iq_pkg::pr_t issue_mul_div_A_pr,
    output iq_pkg::pr_t issue_mul_div_B_pr,
    output iq_pkg::pr_t issue_mul_div_dest_pr,
    output iq_pkg::rob_t issue_mul_div_rob_index
);

    logic [`IQ_ENTRIES-1:0] valid_alu_reg, valid_mul_div, occupied;
    iq_pkg::op_t [`IQ_ENTRIES-1:0] op;
    iq_pkg::pr_t [`IQ_ENTRIES-1:0] A_pr, B_pr, dest_pr;
    logic [`IQ_ENTRIES-1:0] A_ready, B_ready;
    iq_pkg::rob_t [`IQ_ENTRIES-1:0] rob_index;
    logic [`IQ_ENTRIES-1:0] A_forward, B_forward;
    logic [`IQ_ENTRIES-1:0] alu_reg_taken_mask, mul_div_taken_mask;
    iq_pkg::entry_t [`IQ_ENTRIES-1:0] entry_dispatch;

    assign occupied = valid_alu_reg | valid_mul_div;

    entry_shift_queue u_queue (.*);

    dispatch_alloc u_alloc (.*);

    wakeup_match u_wakeup (.*);

    issue_select u_alu_reg_select (
        .entry_valid(valid_alu_reg), .pipeline_ready(alu_reg_pipeline_ready),
        .A_ready, .B_ready, .A_forward, .B_forward,
        .op, .A_pr, .B_pr, .dest_pr, .rob_index,
        .issue_valid(issue_alu_reg_valid), .issue_op(issue_alu_reg_op),
        .issue_A_forward(issue_alu_reg_A_forward),
        .issue_B_forward(issue_alu_reg_B_forward),
        .issue_A_pr(issue_alu_reg_A_pr), .issue_B_pr(issue_alu_reg_B_pr),
        .issue_dest_pr(issue_alu_reg_dest_pr),
        .issue_rob_index(issue_alu_reg_rob_index),
        .taken_mask(alu_reg_taken_mask)
    );

    issue_select u_mul_div_select (
        .entry_valid(valid_mul_div), .pipeline_ready(mul_div_pipeline_ready),
        .A_ready, .B_ready, .A_forward, .B_forward,
        .op, .A_pr, .B_pr, .dest_pr, .rob_index,
        .issue_valid(issue_mul_div_valid), .issue_op(issue_mul_div_op),
        .issue_A_forward(issue_mul_div_A_forward),
        .issue_B_forward(issue_mul_div_B_forward),
        .issue_A_pr(issue_mul_div_A_pr), .issue_B_pr(issue_mul_div_B_pr),
        .issue_dest_pr(issue_mul_div_dest_pr),
        .issue_rob_index(issue_mul_div_rob_index),
        .taken_mask(mul_div_taken_mask)
    );

endmodule

`default_nettype wire

// File: source/entry_shift_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "iq_settings.svh"

module entry_shift_queue (
    input logic CLK,
    input logic nRST,
    input iq_pkg::entry_t [`IQ_ENTRIES-1:0] entry_dispatch,
    input logic [`IQ_ENTRIES-1:0] alu_reg_taken_mask,
    input logic [`IQ_ENTRIES-1:0] mul_div_taken_mask,
    input logic [`IQ_ENTRIES-1:0] A_forward,
    input logic [`IQ_ENTRIES-1:0] B_forward,
    output logic [`IQ_ENTRIES-1:0] valid_alu_reg,
    output logic [`IQ_ENTRIES-1:0] valid_mul_div,
    output iq_pkg::op_t [`IQ_ENTRIES-1:0] op,
    output iq_pkg::pr_t [`IQ_ENTRIES-1:0] A_pr,
    output logic [`IQ_ENTRIES-1:0] A_ready,
    output iq_pkg::pr_t [`IQ_ENTRIES-1:0] B_pr,
    output logic [`IQ_ENTRIES-1:0] B_ready,
    output iq_pkg::pr_t [`IQ_ENTRIES-1:0] dest_pr,
    output iq_pkg::rob_t [`IQ_ENTRIES-1:0] rob_index
);

    // two spare slots above the top read as empty
    iq_pkg::entry_t [`IQ_ENTRIES+1:0] source;
    iq_pkg::entry_t [`IQ_ENTRIES-1:0] next_entry;
    logic [`IQ_ENTRIES:0] alu_mask_ext;
    logic [`IQ_ENTRIES:0] md_mask_ext;
    logic [`IQ_ENTRIES-1:0] take_one;
    logic [`IQ_ENTRIES-1:0] take_two;

    assign alu_mask_ext = {1'b0, alu_reg_taken_mask};
    assign md_mask_ext = {1'b0, mul_div_taken_mask};

    // ------------------------------
    // candidate per position

    always_comb begin
        source = '0;
        for (int j = 0; j < `IQ_ENTRIES; j++) begin
            if (valid_alu_reg[j] | valid_mul_div[j]) begin
                source[j].valid_alu_reg = valid_alu_reg[j];
                source[j].valid_mul_div = valid_mul_div[j];
                source[j].op = op[j];
                source[j].A_pr = A_pr[j];
                source[j].A_ready = A_ready[j] | A_forward[j];
                source[j].B_pr = B_pr[j];
                source[j].B_ready = B_ready[j] | B_forward[j];
                source[j].dest_pr = dest_pr[j];
                source[j].rob_index = rob_index[j];
            end else begin
                source[j] = entry_dispatch[j];
            end
        end
    end

    // ------------------------------
    // collapse by 0, 1 or 2

    always_comb begin
        for (int i = 0; i < `IQ_ENTRIES; i++) begin
            take_one[i] = alu_mask_ext[i] | md_mask_ext[i];
            take_two[i] = (alu_mask_ext[i] & md_mask_ext[i+1])
                | (alu_mask_ext[i+1] & md_mask_ext[i]);
            if (take_two[i]) begin
                next_entry[i] = source[i+2];
            end else if (take_one[i]) begin
                next_entry[i] = source[i+1];
            end else begin
                next_entry[i] = source[i];
            end
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            valid_alu_reg <= '0;
            valid_mul_div <= '0;
        end else begin
            for (int i = 0; i < `IQ_ENTRIES; i++) begin
                valid_alu_reg[i] <= next_entry[i].valid_alu_reg;
                valid_mul_div[i] <= next_entry[i].valid_mul_div;
            end
        end
    end

    always_ff @(posedge CLK) begin
        for (int i = 0; i < `IQ_ENTRIES; i++) begin
            op[i] <= next_entry[i].op;
            A_pr[i] <= next_entry[i].A_pr;
            A_ready[i] <= next_entry[i].A_ready;
            B_pr[i] <= next_entry[i].B_pr;
            B_ready[i] <= next_entry[i].B_ready;
            dest_pr[i] <= next_entry[i].dest_pr;
            rob_index[i] <= next_entry[i].rob_index;
        end
    end

endmodule

`default_nettype wire

// File: source/dispatch_alloc.sv
`timescale 1ns/1ps
`default_nettype none

`include "iq_settings.svh"

module dispatch_alloc (
    input logic [`IQ_ENTRIES-1:0] occupied,
    input logic [`DISPATCH_WAYS-1:0] dispatch_attempt,
    input logic [`DISPATCH_WAYS-1:0] dispatch_valid_alu_reg,
    input logic [`DISPATCH_WAYS-1:0] dispatch_valid_mul_div,
    input iq_pkg::op_t [`DISPATCH_WAYS-1:0] dispatch_op,
    input iq_pkg::pr_t [`DISPATCH_WAYS-1:0] dispatch_A_pr,
    input logic [`DISPATCH_WAYS-1:0] dispatch_A_ready,
    input iq_pkg::pr_t [`DISPATCH_WAYS-1:0] dispatch_B_pr,
    input logic [`DISPATCH_WAYS-1:0] dispatch_B_ready,
    input iq_pkg::pr_t [`DISPATCH_WAYS-1:0] dispatch_dest_pr,
    input iq_pkg::rob_t [`DISPATCH_WAYS-1:0] dispatch_rob_index,
    output logic [`DISPATCH_WAYS-1:0] dispatch_ack,
    output iq_pkg::entry_t [`IQ_ENTRIES-1:0] entry_dispatch
);

    logic [`DISPATCH_WAYS-1:0][`IQ_ENTRIES-1:0] free_vec;
    logic [`DISPATCH_WAYS-1:0][`IQ_ENTRIES-1:0] way_hot;
    iq_pkg::entry_t [`DISPATCH_WAYS-1:0] way_entry;

    // isolate lowest set bit
    function automatic logic [`IQ_ENTRIES-1:0] lowest_one(input logic [`IQ_ENTRIES-1:0] vec);
        return vec & (~vec + 1'b1);
    endfunction

    // cascaded free-slot picks, each way sees what earlier ways left
    always_comb begin
        free_vec[0] = ~occupied;
        way_hot[0] = lowest_one(free_vec[0]) & {`IQ_ENTRIES{dispatch_attempt[0]}};
        for (int w = 1; w < `DISPATCH_WAYS; w++) begin
            free_vec[w] = free_vec[w-1] & ~way_hot[w-1];
            way_hot[w] = lowest_one(free_vec[w]) & {`IQ_ENTRIES{dispatch_attempt[w]}};
        end
        for (int w = 0; w < `DISPATCH_WAYS; w++) begin
            dispatch_ack[w] = |way_hot[w];
        end
    end

    always_comb begin
        for (int w = 0; w < `DISPATCH_WAYS; w++) begin
            way_entry[w].valid_alu_reg = dispatch_valid_alu_reg[w];
            way_entry[w].valid_mul_div = dispatch_valid_mul_div[w];
            way_entry[w].op = dispatch_op[w];
            way_entry[w].A_pr = dispatch_A_pr[w];
            way_entry[w].A_ready = dispatch_A_ready[w];
            way_entry[w].B_pr = dispatch_B_pr[w];
            way_entry[w].B_ready = dispatch_B_ready[w];
            way_entry[w].dest_pr = dispatch_dest_pr[w];
            way_entry[w].rob_index = dispatch_rob_index[w];
        end
    end

    // way to entry routing, zero where nothing lands
    always_comb begin
        entry_dispatch = '0;
        for (int e = 0; e < `IQ_ENTRIES; e++) begin
            for (int w = 0; w < `DISPATCH_WAYS; w++) begin
                entry_dispatch[e] = entry_dispatch[e]
                    | (way_entry[w] & {$bits(iq_pkg::entry_t){way_hot[w][e]}});
            end
        end
    end

endmodule

`default_nettype wire

// File: source/issue_select.sv
`timescale 1ns/1ps
`default_nettype none

`include "iq_settings.svh"

module issue_select (
    input logic [`IQ_ENTRIES-1:0] entry_valid,
    input logic pipeline_ready,
    input logic [`IQ_ENTRIES-1:0] A_ready,
    input logic [`IQ_ENTRIES-1:0] B_ready,
    input logic [`IQ_ENTRIES-1:0] A_forward,
    input logic [`IQ_ENTRIES-1:0] B_forward,
    input iq_pkg::op_t [`IQ_ENTRIES-1:0] op,
    input iq_pkg::pr_t [`IQ_ENTRIES-1:0] A_pr,
    input iq_pkg::pr_t [`IQ_ENTRIES-1:0] B_pr,
    input iq_pkg::pr_t [`IQ_ENTRIES-1:0] dest_pr,
    input iq_pkg::rob_t [`IQ_ENTRIES-1:0] rob_index,
    output logic issue_valid,
    output iq_pkg::op_t issue_op,
    output logic issue_A_forward,
    output logic issue_B_forward,
    output iq_pkg::pr_t issue_A_pr,
    output iq_pkg::pr_t issue_B_pr,
    output iq_pkg::pr_t issue_dest_pr,
    output iq_pkg::rob_t issue_rob_index,
    output logic [`IQ_ENTRIES-1:0] taken_mask
);

    logic [`IQ_ENTRIES-1:0] ready;
    logic [`IQ_ENTRIES-1:0] one_hot;
    // seen[i] is high when some entry below i is ready
    logic [`IQ_ENTRIES:0] seen;

    assign ready = entry_valid & {`IQ_ENTRIES{pipeline_ready}}
        & (A_ready | A_forward) & (B_ready | B_forward);

    assign seen[0] = 1'b0;
    for (genvar i = 0; i < `IQ_ENTRIES; i++) begin : g_pick
        assign seen[i+1] = seen[i] | ready[i];
        assign one_hot[i] = ready[i] & ~seen[i];
    end

    // picked entry and everything above it
    assign taken_mask = seen[`IQ_ENTRIES:1];
    assign issue_valid = |ready;

    // ------------------------------
    // one-hot field mux

    always_comb begin
        issue_op = '0;
        issue_A_forward = 1'b0;
        issue_B_forward = 1'b0;
        issue_A_pr = '0;
        issue_B_pr = '0;
        issue_dest_pr = '0;
        issue_rob_index = '0;
        for (int i = 0; i < `IQ_ENTRIES; i++) begin
            issue_op |= op[i] & {`OP_BITS{one_hot[i]}};
            issue_A_forward |= A_forward[i] & one_hot[i];
            issue_B_forward |= B_forward[i] & one_hot[i];
            issue_A_pr |= A_pr[i] & {`PR_BITS{one_hot[i]}};
            issue_B_pr |= B_pr[i] & {`PR_BITS{one_hot[i]}};
            issue_dest_pr |= dest_pr[i] & {`PR_BITS{one_hot[i]}};
            issue_rob_index |= rob_index[i] & {`ROB_BITS{one_hot[i]}};
        end
    end

endmodule

`default_nettype wire

// File: source/wakeup_match.sv
`timescale 1ns/1ps
`default_nettype none

`include "iq_settings.svh"

module wakeup_match (
    input iq_pkg::pr_t [`IQ_ENTRIES-1:0] A_pr,
    input iq_pkg::pr_t [`IQ_ENTRIES-1:0] B_pr,
    input logic [(1 << `BANK_BITS)-1:0] wb_valid,
    input iq_pkg::upper_pr_t [(1 << `BANK_BITS)-1:0] wb_upper_pr,
    output logic [`IQ_ENTRIES-1:0] A_forward,
    output logic [`IQ_ENTRIES-1:0] B_forward
);

    logic [`IQ_ENTRIES-1:0][`BANK_BITS-1:0] A_bank;
    logic [`IQ_ENTRIES-1:0][`BANK_BITS-1:0] B_bank;

    for (genvar i = 0; i < `IQ_ENTRIES; i++) begin : g_entry
        // bank is the low bits of the register number
        assign A_bank[i] = A_pr[i][`BANK_BITS-1:0];
        assign B_bank[i] = B_pr[i][`BANK_BITS-1:0];

        // only the upper bits travel on that bank's bus
        assign A_forward[i] = wb_valid[A_bank[i]]
            & (wb_upper_pr[A_bank[i]] == A_pr[i][`PR_BITS-1:`BANK_BITS]);
        assign B_forward[i] = wb_valid[B_bank[i]]
            & (wb_upper_pr[B_bank[i]] == B_pr[i][`PR_BITS-1:`BANK_BITS]);
    end

endmodule

`default_nettype wire

// File: source/iq_pkg.sv
`default_nettype none

`include "iq_settings.svh"

package iq_pkg;

    typedef logic [`OP_BITS-1:0] op_t;
    typedef logic [`PR_BITS-1:0] pr_t;
    typedef logic [`PR_BITS-`BANK_BITS-1:0] upper_pr_t;
    typedef logic [`ROB_BITS-1:0] rob_t;

    // one queue slot
    typedef struct packed {
        logic valid_alu_reg;
        logic valid_mul_div;
        op_t op;
        pr_t A_pr;
        logic A_ready;
        pr_t B_pr;
        logic B_ready;
        pr_t dest_pr;
        rob_t rob_index;
    } entry_t;

endpackage

`default_nettype wire

// File: source/iq_settings.svh
`ifndef IQ_SETTINGS_SVH
`define IQ_SETTINGS_SVH

// queue geometry
`define IQ_ENTRIES 8
`define DISPATCH_WAYS 2

// operation code width
`define OP_BITS 4

// physical register numbering
// bank index is the low bits of the register number, 4 banks
`define PR_BITS 6
`define BANK_BITS 2

// reorder buffer
`define ROB_BITS 6

`endif
